//--- logic/mont_pkg.sv
package mont_pkg;

    // Operand and datapath widths
    localparam int OP_W      = 64;
    localparam int ADD_W     = OP_W + 3;
    localparam int EXT_W     = OP_W + 4;
    localparam int WORD_W    = 17;
    localparam int ADD_WORDS = EXT_W / WORD_W;
    localparam int WCNT_W    = $clog2(ADD_WORDS);
    localparam int DIGITS    = OP_W / 2;
    localparam int DCNT_W    = $clog2(DIGITS + 1);

    typedef logic [OP_W-1:0]   operand_t;
    typedef logic [ADD_W-1:0]  addend_t;
    typedef logic [EXT_W-1:0]  ext_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [WCNT_W-1:0] word_cnt_t;
    typedef logic [DCNT_W-1:0] digit_cnt_t;

    // Adder operand A source
    typedef enum logic [1:0] {ACC_C, ACC_B, ACC_M} acc_sel_e;

    // Adder operand B source
    typedef enum logic [2:0] {
        ADD_B2, ADD_M2, ADD_B_DIGIT, ADD_M_DIGIT, ADD_M
    } addend_sel_e;

    typedef enum logic [2:0] {
        IDLE, B3_RUN, M3_RUN, BDIG_RUN, MDIG_RUN, SUB_RUN, FIX_RUN, DONE
    } mont_state_e;

endpackage

//--- logic/adder_if.sv
`timescale 1ns/1ps

interface adder_if;

    logic               start;
    logic               subtract;
    mont_pkg::addend_t  in_a;
    mont_pkg::addend_t  in_b;
    mont_pkg::ext_t     sum;
    logic               done;

    // Sequencer side
    modport ctrl (output start, output subtract, input done);

    // Operand muxes and result capture
    modport dp (output in_a, output in_b, input sum);

    modport adder (
        input  start,
        input  subtract,
        input  in_a,
        input  in_b,
        output sum,
        output done
    );

endinterface

//--- logic/mont_ctrl_if.sv
`timescale 1ns/1ps

interface mont_ctrl_if;

    logic                   load_inputs;
    mont_pkg::acc_sel_e     acc_sel;
    mont_pkg::addend_sel_e  addend_sel;
    logic                   store_b3;
    logic                   store_m3;
    logic                   store_c;
    logic                   shift_c;
    logic                   shift_a;
    // Sign of the accumulator
    logic                   c_neg;

    modport ctrl (
        output load_inputs,
        output acc_sel,
        output addend_sel,
        output store_b3,
        output store_m3,
        output store_c,
        output shift_c,
        output shift_a,
        input  c_neg
    );

    modport dp (
        input  load_inputs,
        input  acc_sel,
        input  addend_sel,
        input  store_b3,
        input  store_m3,
        input  store_c,
        input  shift_c,
        input  shift_a,
        output c_neg
    );

endinterface

//--- logic/mpadder.sv
`timescale 1ns/1ps

module mpadder (
    input  logic   clk,
    input  logic   resetn,
    adder_if.adder bus
);

    mont_pkg::ext_t       ext_a;
    mont_pkg::ext_t       ext_b;
    mont_pkg::word_cnt_t  idx;
    mont_pkg::word_cnt_t  cnt;
    mont_pkg::word_t      word_a;
    mont_pkg::word_t      word_b;
    logic [mont_pkg::WORD_W:0] word_sum;
    logic                 carry;
    logic                 carry_in;
    logic                 busy;
    logic                 active;
    logic                 last_word;

    assign ext_a = {1'b0, bus.in_a};
    assign ext_b = {1'b0, bus.in_b};

    // Chunk 0 is handled in the start cycle itself
    assign active    = bus.start || busy;
    assign idx       = bus.start ? '0 : cnt;
    assign carry_in  = bus.start ? bus.subtract : carry;
    assign last_word = idx == mont_pkg::word_cnt_t'(mont_pkg::ADD_WORDS - 1);

    assign word_a = ext_a[idx * mont_pkg::WORD_W +: mont_pkg::WORD_W];
    // Subtract as A + ~B + 1, the +1 coming in as the first carry
    assign word_b = ext_b[idx * mont_pkg::WORD_W +: mont_pkg::WORD_W]
                    ^ {mont_pkg::WORD_W{bus.subtract}};
    assign word_sum = word_a + word_b + carry_in;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy     <= 1'b0;
            cnt      <= '0;
            carry    <= 1'b0;
            bus.done <= 1'b0;
        end else begin
            bus.done <= active && last_word;
            if (active) begin
                carry <= word_sum[mont_pkg::WORD_W];
                cnt   <= idx + 1'b1;
                busy  <= !last_word;
            end
        end
    end

    // Sum holds after done until the next start overwrites it
    always_ff @(posedge clk) begin
        if (active) begin
            bus.sum[idx * mont_pkg::WORD_W +: mont_pkg::WORD_W]
                <= word_sum[mont_pkg::WORD_W-1:0];
        end
    end

endmodule

//--- logic/mont_datapath.sv
`timescale 1ns/1ps

module mont_datapath (
    input  logic               clk,
    input  logic               resetn,
    input  mont_pkg::operand_t in_a,
    input  mont_pkg::operand_t in_b,
    input  mont_pkg::operand_t in_m,
    output mont_pkg::operand_t result,
    mont_ctrl_if.dp            ctrl,
    adder_if.dp                add
);

    mont_pkg::operand_t a;
    mont_pkg::operand_t b;
    mont_pkg::operand_t m;
    mont_pkg::addend_t  b3;
    mont_pkg::addend_t  m3;
    mont_pkg::ext_t     c;
    logic [1:0]         q_digit;
    mont_pkg::addend_t  b_mult;
    mont_pkg::addend_t  m_mult;

    // 0, x, 2x or 3x for one radix-4 digit
    function automatic mont_pkg::addend_t pick_multiple(
        input logic [1:0]         digit,
        input mont_pkg::operand_t x,
        input mont_pkg::addend_t  x3
    );
        mont_pkg::addend_t mult;
        case (digit)
            2'd0:    mult = '0;
            2'd1:    mult = {3'b000, x};
            2'd2:    mult = {2'b00, x, 1'b0};
            default: mult = x3;
        endcase
        return mult;
    endfunction

    // q = c * (-m^-1) mod 4, which is c for m = 3 mod 4 and -c for m = 1 mod 4
    assign q_digit = {c[1] ^ (c[0] & ~m[1]), c[0]};

    assign b_mult = pick_multiple(a[1:0], b, b3);
    assign m_mult = pick_multiple(q_digit, m, m3);

    always_comb begin
        case (ctrl.acc_sel)
            mont_pkg::ACC_B: add.in_a = {3'b000, b};
            mont_pkg::ACC_M: add.in_a = {3'b000, m};
            default:         add.in_a = c[mont_pkg::ADD_W-1:0];
        endcase
    end

    always_comb begin
        case (ctrl.addend_sel)
            mont_pkg::ADD_B2:      add.in_b = {2'b00, b, 1'b0};
            mont_pkg::ADD_M2:      add.in_b = {2'b00, m, 1'b0};
            mont_pkg::ADD_B_DIGIT: add.in_b = b_mult;
            mont_pkg::ADD_M_DIGIT: add.in_b = m_mult;
            default:               add.in_b = {3'b000, m};
        endcase
    end

    always_ff @(posedge clk) begin
        if (ctrl.load_inputs) begin
            a <= in_a;
            b <= in_b;
            m <= in_m;
        end else if (ctrl.shift_a) begin
            // Next a-digit into the low bits
            a <= {2'b00, a[mont_pkg::OP_W-1:2]};
        end
        if (ctrl.store_b3) begin
            b3 <= add.sum[mont_pkg::ADD_W-1:0];
        end
        if (ctrl.store_m3) begin
            m3 <= add.sum[mont_pkg::ADD_W-1:0];
        end
    end

    // Accumulator, also the result register
    always_ff @(posedge clk) begin
        if (!resetn) begin
            c <= '0;
        end else if (ctrl.load_inputs) begin
            c <= '0;
        end else if (ctrl.store_c) begin
            c <= ctrl.shift_c ? {2'b00, add.sum[mont_pkg::EXT_W-1:2]} : add.sum;
        end
    end

    assign ctrl.c_neg = c[mont_pkg::EXT_W-1];
    assign result     = c[mont_pkg::OP_W-1:0];

endmodule

//--- logic/mont_controller.sv
`timescale 1ns/1ps

module mont_controller (
    input  logic      clk,
    input  logic      resetn,
    input  logic      start,
    output logic      done,
    mont_ctrl_if.ctrl ctrl,
    adder_if.ctrl     add
);

    mont_pkg::mont_state_e state;
    mont_pkg::mont_state_e state_next;
    mont_pkg::digit_cnt_t  digit_cnt;
    logic                  enter;
    logic                  in_run;
    logic                  last_digit;
    logic                  sub_over;

    assign in_run     = (state != mont_pkg::IDLE) && (state != mont_pkg::DONE);
    assign last_digit = digit_cnt == mont_pkg::digit_cnt_t'(mont_pkg::DIGITS - 1);

    // Previous subtraction went negative, so stop and add M back
    assign sub_over = (state == mont_pkg::SUB_RUN) && enter && ctrl.c_neg;

    always_comb begin
        state_next = state;
        case (state)
            mont_pkg::IDLE: begin
                if (start) begin
                    state_next = mont_pkg::B3_RUN;
                end
            end
            mont_pkg::B3_RUN: begin
                if (add.done) begin
                    state_next = mont_pkg::M3_RUN;
                end
            end
            mont_pkg::M3_RUN: begin
                if (add.done) begin
                    state_next = mont_pkg::BDIG_RUN;
                end
            end
            mont_pkg::BDIG_RUN: begin
                if (add.done) begin
                    state_next = mont_pkg::MDIG_RUN;
                end
            end
            mont_pkg::MDIG_RUN: begin
                if (add.done) begin
                    state_next = last_digit ? mont_pkg::SUB_RUN : mont_pkg::BDIG_RUN;
                end
            end
            mont_pkg::SUB_RUN: begin
                if (sub_over) begin
                    state_next = mont_pkg::FIX_RUN;
                end
            end
            mont_pkg::FIX_RUN: begin
                if (add.done) begin
                    state_next = mont_pkg::DONE;
                end
            end
            default: state_next = mont_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= mont_pkg::IDLE;
            enter     <= 1'b0;
            digit_cnt <= '0;
            done      <= 1'b0;
        end else begin
            state <= state_next;
            // A finished subtraction re-enters SUB_RUN
            enter <= (state_next != state) || ((state == mont_pkg::SUB_RUN) && add.done);
            done  <= state_next == mont_pkg::DONE;
            if (state == mont_pkg::IDLE) begin
                digit_cnt <= '0;
            end else if ((state == mont_pkg::MDIG_RUN) && add.done) begin
                digit_cnt <= digit_cnt + 1'b1;
            end
        end
    end

    assign add.start    = enter && in_run && !sub_over;
    assign add.subtract = state == mont_pkg::SUB_RUN;

    // Operand selects and strobes, stores land on the adder done
    always_comb begin
        ctrl.load_inputs = (state == mont_pkg::IDLE) && start;
        ctrl.acc_sel     = mont_pkg::ACC_C;
        ctrl.addend_sel  = mont_pkg::ADD_M;
        ctrl.store_b3    = 1'b0;
        ctrl.store_m3    = 1'b0;
        ctrl.store_c     = 1'b0;
        ctrl.shift_c     = 1'b0;
        ctrl.shift_a     = 1'b0;
        case (state)
            mont_pkg::B3_RUN: begin
                ctrl.acc_sel    = mont_pkg::ACC_B;
                ctrl.addend_sel = mont_pkg::ADD_B2;
                ctrl.store_b3   = add.done;
            end
            mont_pkg::M3_RUN: begin
                ctrl.acc_sel    = mont_pkg::ACC_M;
                ctrl.addend_sel = mont_pkg::ADD_M2;
                ctrl.store_m3   = add.done;
            end
            mont_pkg::BDIG_RUN: begin
                ctrl.addend_sel = mont_pkg::ADD_B_DIGIT;
                ctrl.store_c    = add.done;
                ctrl.shift_a    = add.done;
            end
            mont_pkg::MDIG_RUN: begin
                ctrl.addend_sel = mont_pkg::ADD_M_DIGIT;
                ctrl.store_c    = add.done;
                ctrl.shift_c    = add.done;
            end
            mont_pkg::SUB_RUN,
            mont_pkg::FIX_RUN: begin
                ctrl.store_c = add.done;
            end
            default: begin
            end
        endcase
    end

endmodule

//--- logic/montgomery.sv
`timescale 1ns/1ps

module montgomery (
    input  logic               clk,
    input  logic               resetn,
    input  logic               start,
    input  mont_pkg::operand_t in_a,
    input  mont_pkg::operand_t in_b,
    input  mont_pkg::operand_t in_m,
    output mont_pkg::operand_t result,
    output logic               done
);

    mont_ctrl_if ctrl_bus ();
    adder_if     add_bus ();

    mont_controller u_ctrl (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .done   (done),
        .ctrl   (ctrl_bus.ctrl),
        .add    (add_bus.ctrl)
    );

    mont_datapath u_dp (
        .clk    (clk),
        .resetn (resetn),
        .in_a   (in_a),
        .in_b   (in_b),
        .in_m   (in_m),
        .result (result),
        .ctrl   (ctrl_bus.dp),
        .add    (add_bus.dp)
    );

    // Shared word-serial adder
    mpadder u_adder (
        .clk    (clk),
        .resetn (resetn),
        .bus    (add_bus.adder)
    );

endmodule

//--- test/montgomery_chk.sv
`timescale 1ns/1ps

module montgomery_chk (
    input logic clk,
    input logic resetn,
    input logic done,
    input logic accepted
);

    logic        armed;
    int unsigned fail_count = 0;

    // Set by an accepted start, cleared by the done that ends it
    always_ff @(posedge clk) begin
        if (!resetn) begin
            armed <= 1'b0;
        end else if (accepted) begin
            armed <= 1'b1;
        end else if (done) begin
            armed <= 1'b0;
        end
    end

    done_in_reset: assert property (@(posedge clk) (!resetn && $past(!resetn)) |-> !done)
        else begin
            fail_count++;
            $error("done high while resetn is low");
        end

    done_single: assert property (@(posedge clk) disable iff (!resetn) done |=> !done)
        else begin
            fail_count++;
            $error("done held for two cycles");
        end

    done_after_start: assert property (@(posedge clk) disable iff (!resetn) done |-> armed)
        else begin
            fail_count++;
            $error("done without an accepted start");
        end

endmodule

bind montgomery montgomery_chk u_chk (
    .clk      (clk),
    .resetn   (resetn),
    .done     (done),
    .accepted (ctrl_bus.load_inputs)
);

//--- test/tb_montgomery.sv
`timescale 1ns/1ps

module tb_montgomery;

    localparam int NUM_RANDOM      = 20;
    localparam int NUM_OPS         = NUM_RANDOM + 6;
    localparam int OP_CYCLES       = (mont_pkg::DIGITS * 2 + 8) * (mont_pkg::ADD_WORDS + 2);
    localparam int WATCHDOG_CYCLES = NUM_OPS * OP_CYCLES * 2;

    typedef logic [2*mont_pkg::OP_W-1:0] wide_t;

    logic               clk;
    logic               resetn;
    logic               start;
    mont_pkg::operand_t in_a;
    mont_pkg::operand_t in_b;
    mont_pkg::operand_t in_m;
    mont_pkg::operand_t result;
    logic               done;
    integer             seed;
    int                 errors = 0;
    int                 checks = 0;
    int                 done_cnt = 0;

    montgomery i_montgomery (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .in_a   (in_a),
        .in_b   (in_b),
        .in_m   (in_m),
        .result (result),
        .done   (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(negedge clk) begin
        if (done) begin
            done_cnt++;
        end
    end

    function automatic mont_pkg::operand_t rand_operand();
        return {$random(seed), $random(seed)};
    endfunction

    // Odd, full width modulus
    function automatic mont_pkg::operand_t rand_modulus();
        mont_pkg::operand_t x;
        x = rand_operand();
        x[mont_pkg::OP_W-1] = 1'b1;
        x[0] = 1'b1;
        return x;
    endfunction

    task automatic check_value(input string name, input mont_pkg::operand_t expected,
                               input mont_pkg::operand_t actual);
        checks++;
        assert (actual === expected)
        else begin
            errors++;
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // result * 2^OP_W must match a * b modulo m, and result must stay below m
    task automatic check_result(input string name, input mont_pkg::operand_t a,
                                input mont_pkg::operand_t b, input mont_pkg::operand_t m);
        wide_t prod;
        wide_t scaled;
        prod   = (wide_t'(a) * wide_t'(b)) % wide_t'(m);
        scaled = {result, mont_pkg::operand_t'(0)} % wide_t'(m);
        check_value({name, " congruence"}, prod[mont_pkg::OP_W-1:0],
                    scaled[mont_pkg::OP_W-1:0]);
        checks++;
        assert (result < m)
        else begin
            errors++;
            $display("ERR %s range: expected below %h, actual %h", name, m, result);
        end
    endtask

    task automatic drive_start(input mont_pkg::operand_t a, input mont_pkg::operand_t b,
                               input mont_pkg::operand_t m);
        @(posedge clk);
        start <= 1'b1;
        in_a  <= a;
        in_b  <= b;
        in_m  <= m;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_done();
        @(negedge clk);
        while (!done) begin
            @(negedge clk);
        end
    endtask

    task automatic run_op(input string name, input mont_pkg::operand_t a,
                          input mont_pkg::operand_t b, input mont_pkg::operand_t m);
        drive_start(a, b, m);
        wait_done();
        check_result(name, a, b, m);
    endtask

    initial begin
        mont_pkg::operand_t a;
        mont_pkg::operand_t b;
        mont_pkg::operand_t m;
        int                 done_before;
        seed   = 32'ha928229f;
        resetn = 1'b0;
        start  = 1'b0;
        in_a   = '0;
        in_b   = '0;
        in_m   = '0;
        repeat (5) @(posedge clk);
        resetn <= 1'b1;

        // Idle after reset
        repeat (5) begin
            @(negedge clk);
            check_value("reset done", '0, mont_pkg::operand_t'(done));
            check_value("reset result", '0, result);
        end

        for (int i = 0; i < NUM_RANDOM; i++) begin
            m = rand_modulus();
            a = rand_operand() % m;
            b = rand_operand() % m;
            run_op($sformatf("random %0d", i), a, b, m);
        end

        m = rand_modulus();
        run_op("zero operand", '0, m - 1'b1, m);
        check_value("zero operand result", '0, result);
        // Both quotient digit branches
        m[1] = 1'b0;
        run_op("unit operands m mod 4 = 1", mont_pkg::operand_t'(1), mont_pkg::operand_t'(1), m);
        m[1] = 1'b1;
        run_op("unit operands m mod 4 = 3", mont_pkg::operand_t'(1), mont_pkg::operand_t'(1), m);

        // Second start while busy
        m = rand_modulus();
        a = rand_operand() % m;
        b = rand_operand() % m;
        drive_start(a, b, m);
        done_before = done_cnt;
        repeat (20) @(posedge clk);
        drive_start(rand_operand(), rand_operand(), rand_modulus());
        wait_done();
        check_result("busy start", a, b, m);
        repeat (5) @(negedge clk);
        checks++;
        assert (done_cnt - done_before == 1)
        else begin
            errors++;
            $display("ERR busy start done count: expected 1, actual %0d",
                     done_cnt - done_before);
        end

        // Result holds while inputs move
        @(posedge clk);
        in_a <= ~in_a;
        in_b <= ~in_b;
        in_m <= ~in_m;
        repeat (10) @(negedge clk);
        check_result("result hold", a, b, m);

        $display("Checks: %0d, value errors: %0d, assertion errors: %0d",
                 checks, errors, i_montgomery.u_chk.fail_count);
        if (errors == 0 && i_montgomery.u_chk.fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, done never arrived", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- montgomery.f
logic/mont_pkg.sv
logic/adder_if.sv
logic/mont_ctrl_if.sv
logic/mpadder.sv
logic/mont_datapath.sv
logic/mont_controller.sv
logic/montgomery.sv
test/montgomery_chk.sv
test/tb_montgomery.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_montgomery -f montgomery.f -Mdir obj_dir

./obj_dir/Vtb_montgomery +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -qx "STATUS: PASS" sim.log; then
    exit 0
fi
exit 1
